// File: design/core_pkg.sv
// ISA-level widths, opcodes and reset constants, imported by every stage of the core
package core_pkg;

    // architectural sizes
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     instr_t;

    // reset values
    localparam xlen_t  RESET_PC  = '0;
    // addi x0, x0, 0 used as the pipeline bubble
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // subset of rv32i major opcodes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        STORE  = 7'b0100011
    } opcode_e;

    // alu funct3
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;
    // branch and store funct3
    localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
    localparam logic [2:0] FUNCT3_BNE     = 3'b001;
    localparam logic [2:0] FUNCT3_SW      = 3'b010;

endpackage

// File: design/ctrl_pkg.sv
// pipeline control encodings passed from the control unit to the datapath stages
package ctrl_pkg;

    // alu operation, pass_b carries the lui immediate straight through
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B
    } alu_op_e;

    // decode operand source
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXE,
        FWD_MEM
    } fwd_sel_e;

    // next pc source
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL
    } pc_sel_e;

endpackage

// File: design/fetch_stage.sv
// fetch stage, owns the pc, picks the next pc and loads the fetch/decode register
module fetch_stage (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_hold,
    input  logic             i_flush,
    input  ctrl_pkg::pc_sel_e i_pc_sel,
    input  core_pkg::xlen_t  i_branch_target,
    input  core_pkg::xlen_t  i_jal_target,
    input  core_pkg::instr_t i_instr,
    output core_pkg::xlen_t  o_pc,
    output core_pkg::instr_t o_id_instr,
    output core_pkg::xlen_t  o_id_pc
);
    import core_pkg::*;
    import ctrl_pkg::*;

    xlen_t pc;
    xlen_t pc_next;

    // targets come from decode, so a taken transfer lands one fetch late
    always_comb begin
        case (i_pc_sel)
            PC_BRANCH: pc_next = i_branch_target;
            PC_JAL:    pc_next = i_jal_target;
            default:   pc_next = pc + xlen_t'(4);
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= RESET_PC;
        end else if (!i_hold) begin
            pc <= pc_next;
        end
    end

    // instruction word, bubble after reset and on flush
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_instr <= NOP_INSTR;
        end else if (!i_hold) begin
            o_id_instr <= i_flush ? NOP_INSTR : i_instr;
        end
    end

    // pc travels with the word, only read for targets
    always_ff @(posedge i_clk) begin
        if (!i_hold) begin
            o_id_pc <= pc;
        end
    end

    assign o_pc = pc;

endmodule

// File: design/control_unit.sv
// decode control, forwarding selection and branch decision for the instruction in decode
module control_unit (
    input  core_pkg::instr_t    i_instr,
    input  core_pkg::reg_addr_t i_exe_rd,
    input  core_pkg::reg_addr_t i_mem_rd,
    input  logic                i_exe_wreg,
    input  logic                i_mem_wreg,
    input  logic                i_equal,
    output ctrl_pkg::alu_op_e   o_alu_op,
    output logic                o_alu_imm,
    output logic                o_wreg,
    output logic                o_wmem,
    output logic                o_link,
    output ctrl_pkg::fwd_sel_e  o_fwd_a,
    output ctrl_pkg::fwd_sel_e  o_fwd_b,
    output ctrl_pkg::pc_sel_e   o_pc_sel,
    output logic                o_flush
);
    import core_pkg::*;
    import ctrl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    alu_op_e    funct_op;

    assign opcode    = opcode_e'(i_instr[6:0]);
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];
    assign rs1       = i_instr[19:15];
    assign rs2       = i_instr[24:20];

    // alu op shared by register and immediate forms
    always_comb begin
        case (funct3)
            // sub exists only in the register form
            FUNCT3_ADD_SUB: funct_op = (opcode == OP && funct7_b5) ? SUB : ADD;
            FUNCT3_SLL:     funct_op = SLL;
            FUNCT3_SLT:     funct_op = SLT;
            FUNCT3_SLTU:    funct_op = SLTU;
            FUNCT3_XOR:     funct_op = XOR;
            FUNCT3_SRL_SRA: funct_op = funct7_b5 ? SRA : SRL;
            FUNCT3_OR:      funct_op = OR;
            default:        funct_op = AND;
        endcase
    end

    always_comb begin
        // defaults describe a bubble
        o_alu_op  = ADD;
        o_alu_imm = 1'b0;
        o_wreg    = 1'b0;
        o_wmem    = 1'b0;
        o_link    = 1'b0;
        o_pc_sel  = PC_PLUS4;
        case (opcode)
            OP: begin
                o_alu_op = funct_op;
                o_wreg   = 1'b1;
            end
            OP_IMM: begin
                o_alu_op  = funct_op;
                o_alu_imm = 1'b1;
                o_wreg    = 1'b1;
            end
            LUI: begin
                o_alu_op  = PASS_B;
                o_alu_imm = 1'b1;
                o_wreg    = 1'b1;
            end
            BRANCH: begin
                if ((funct3 == FUNCT3_BEQ && i_equal) || (funct3 == FUNCT3_BNE && !i_equal)) begin
                    o_pc_sel = PC_BRANCH;
                end
            end
            JAL: begin
                // link value pc+4 replaces the alu result
                o_wreg   = 1'b1;
                o_link   = 1'b1;
                o_pc_sel = PC_JAL;
            end
            STORE: begin
                // word stores only, address is rs1 + s-imm
                o_wmem    = (funct3 == FUNCT3_SW);
                o_alu_imm = 1'b1;
            end
            default: ;
        endcase
    end

    // nearest producer wins, x0 never forwards
    always_comb begin
        o_fwd_a = FWD_REG;
        if (i_exe_wreg && i_exe_rd != '0 && i_exe_rd == rs1) begin
            o_fwd_a = FWD_EXE;
        end else if (i_mem_wreg && i_mem_rd != '0 && i_mem_rd == rs1) begin
            o_fwd_a = FWD_MEM;
        end
        o_fwd_b = FWD_REG;
        if (i_exe_wreg && i_exe_rd != '0 && i_exe_rd == rs2) begin
            o_fwd_b = FWD_EXE;
        end else if (i_mem_wreg && i_mem_rd != '0 && i_mem_rd == rs2) begin
            o_fwd_b = FWD_MEM;
        end
    end

    // squash the word fetched behind a taken transfer
    assign o_flush = (o_pc_sel != PC_PLUS4);

endmodule

// File: design/regfile.sv
// integer register file, two read ports, one write port, writeback bypassed to decode
module regfile (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  core_pkg::reg_addr_t i_rs1,
    input  core_pkg::reg_addr_t i_rs2,
    input  core_pkg::reg_addr_t i_rd,
    input  logic                i_we,
    input  core_pkg::xlen_t     i_wdata,
    output core_pkg::xlen_t     o_rdata1,
    output core_pkg::xlen_t     o_rdata2
);
    import core_pkg::*;

    // x0 has no storage
    xlen_t regs [1:NUM_REGS-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // same-cycle write shows up on the read
    assign o_rdata1 = (i_rs1 == '0) ? '0 :
                      (i_we && i_rd == i_rs1) ? i_wdata : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 :
                      (i_we && i_rd == i_rs2) ? i_wdata : regs[i_rs2];

endmodule

// File: design/decode_stage.sv
// decode datapath, immediates, operand forwarding, branch compare and the decode/execute register
module decode_stage (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_hold,
    input  core_pkg::instr_t    i_instr,
    input  core_pkg::xlen_t     i_pc,
    input  core_pkg::xlen_t     i_rdata1,
    input  core_pkg::xlen_t     i_rdata2,
    input  core_pkg::xlen_t     i_exe_result,
    input  core_pkg::xlen_t     i_mem_result,
    input  ctrl_pkg::fwd_sel_e  i_fwd_a,
    input  ctrl_pkg::fwd_sel_e  i_fwd_b,
    input  ctrl_pkg::alu_op_e   i_alu_op,
    input  logic                i_alu_imm,
    input  logic                i_wreg,
    input  logic                i_wmem,
    input  logic                i_link,
    output logic                o_equal,
    output core_pkg::xlen_t     o_branch_target,
    output core_pkg::xlen_t     o_jal_target,
    output core_pkg::xlen_t     o_exe_a,
    output core_pkg::xlen_t     o_exe_b,
    output core_pkg::xlen_t     o_exe_imm,
    output core_pkg::xlen_t     o_exe_pc4,
    output core_pkg::reg_addr_t o_exe_rd,
    output ctrl_pkg::alu_op_e   o_exe_alu_op,
    output logic                o_exe_alu_imm,
    output logic                o_exe_wreg,
    output logic                o_exe_wmem,
    output logic                o_exe_link
);
    import core_pkg::*;
    import ctrl_pkg::*;

    xlen_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t   imm;
    xlen_t   op_a, op_b;
    opcode_e opcode;

    function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t reg_val, xlen_t exe_val,
                                      xlen_t mem_val);
        case (sel)
            FWD_EXE: return exe_val;
            FWD_MEM: return mem_val;
            default: return reg_val;
        endcase
    endfunction

    assign opcode = opcode_e'(i_instr[6:0]);

    // rv32i immediate formats
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // immediate for the alu, branch and jal use theirs directly
    assign imm = (opcode == STORE) ? imm_s :
                 (opcode == LUI)   ? imm_u : imm_i;

    assign op_a    = fwd_mux(i_fwd_a, i_rdata1, i_exe_result, i_mem_result);
    assign op_b    = fwd_mux(i_fwd_b, i_rdata2, i_exe_result, i_mem_result);
    assign o_equal = (op_a == op_b);

    assign o_branch_target = i_pc + imm_b;
    assign o_jal_target    = i_pc + imm_j;

    // control bits cleared on reset so the stage starts empty
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_exe_wreg <= 1'b0;
            o_exe_wmem <= 1'b0;
        end else if (!i_hold) begin
            o_exe_wreg <= i_wreg;
            o_exe_wmem <= i_wmem;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_hold) begin
            o_exe_a       <= op_a;
            o_exe_b       <= op_b;
            o_exe_imm     <= imm;
            o_exe_pc4     <= i_pc + xlen_t'(4);
            o_exe_rd      <= i_instr[11:7];
            o_exe_alu_op  <= i_alu_op;
            o_exe_alu_imm <= i_alu_imm;
            o_exe_link    <= i_link;
        end
    end

endmodule

// File: design/execute_stage.sv
// execute, memory and writeback stages, alu, store request port and register file write
module execute_stage (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  core_pkg::xlen_t     i_exe_a,
    input  core_pkg::xlen_t     i_exe_b,
    input  core_pkg::xlen_t     i_exe_imm,
    input  core_pkg::xlen_t     i_exe_pc4,
    input  core_pkg::reg_addr_t i_exe_rd,
    input  ctrl_pkg::alu_op_e   i_exe_alu_op,
    input  logic                i_exe_alu_imm,
    input  logic                i_exe_wreg,
    input  logic                i_exe_wmem,
    input  logic                i_exe_link,
    input  logic                i_data_gnt,
    output core_pkg::xlen_t     o_exe_result,
    output core_pkg::xlen_t     o_mem_result,
    output core_pkg::reg_addr_t o_exe_rd,
    output core_pkg::reg_addr_t o_mem_rd,
    output core_pkg::reg_addr_t o_wb_rd,
    output logic                o_exe_wreg,
    output logic                o_mem_wreg,
    output logic                o_wb_we,
    output core_pkg::xlen_t     o_wb_data,
    output logic                o_data_req,
    output core_pkg::xlen_t     o_data_addr,
    output core_pkg::xlen_t     o_data_wdata,
    output logic                o_hold
);
    import core_pkg::*;
    import ctrl_pkg::*;

    xlen_t alu_b;
    xlen_t alu_r;
    xlen_t mem_wdata;
    logic  mem_wmem;
    logic  wb_wreg;

    assign alu_b = i_exe_alu_imm ? i_exe_imm : i_exe_b;

    always_comb begin
        case (i_exe_alu_op)
            SUB:     alu_r = i_exe_a - alu_b;
            AND:     alu_r = i_exe_a & alu_b;
            OR:      alu_r = i_exe_a | alu_b;
            XOR:     alu_r = i_exe_a ^ alu_b;
            SLT:     alu_r = {{(XLEN-1){1'b0}}, $signed(i_exe_a) < $signed(alu_b)};
            SLTU:    alu_r = {{(XLEN-1){1'b0}}, i_exe_a < alu_b};
            // shift amount is the low five bits
            SLL:     alu_r = i_exe_a << alu_b[4:0];
            SRL:     alu_r = i_exe_a >> alu_b[4:0];
            SRA:     alu_r = xlen_t'($signed(i_exe_a) >>> alu_b[4:0]);
            PASS_B:  alu_r = alu_b;
            default: alu_r = i_exe_a + alu_b;
        endcase
    end

    // jal writes its return address
    assign o_exe_result = i_exe_link ? i_exe_pc4 : alu_r;
    assign o_exe_rd     = i_exe_rd;
    assign o_exe_wreg   = i_exe_wreg;

    // pending store without grant freezes the whole pipe
    assign o_hold = mem_wmem && !i_data_gnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wreg <= 1'b0;
            mem_wmem   <= 1'b0;
            wb_wreg    <= 1'b0;
        end else if (!o_hold) begin
            o_mem_wreg <= i_exe_wreg;
            mem_wmem   <= i_exe_wmem;
            wb_wreg    <= o_mem_wreg;
        end
    end

    // payload of memory and writeback
    always_ff @(posedge i_clk) begin
        if (!o_hold) begin
            o_mem_result <= o_exe_result;
            mem_wdata    <= i_exe_b;
            o_mem_rd     <= i_exe_rd;
            o_wb_data    <= o_mem_result;
            o_wb_rd      <= o_mem_rd;
        end
    end

    // address and data held by the stalled register until granted
    assign o_data_req   = mem_wmem;
    assign o_data_addr  = o_mem_result;
    assign o_data_wdata = mem_wdata;

    // no register write while stalled
    assign o_wb_we = wb_wreg && !o_hold;

endmodule

// File: design/core_top.sv
// top level of the five-stage core, exposes the fetch port and the store request/grant port
module core_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    output core_pkg::xlen_t  o_instr_addr,
    input  core_pkg::instr_t i_instr_rdata,
    output logic             o_data_req,
    output core_pkg::xlen_t  o_data_addr,
    output core_pkg::xlen_t  o_data_wdata,
    input  logic             i_data_gnt
);
    import core_pkg::*;
    import ctrl_pkg::*;

    // global stall, store waiting on grant
    logic      hold;
    logic      flush;
    pc_sel_e   pc_sel;
    xlen_t     branch_target;
    xlen_t     jal_target;

    // decode side
    instr_t    id_instr;
    xlen_t     id_pc;
    xlen_t     rdata1;
    xlen_t     rdata2;
    logic      equal;
    alu_op_e   alu_op;
    logic      alu_imm;
    logic      wreg;
    logic      wmem;
    logic      link;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    // decode/execute register
    xlen_t     exe_a;
    xlen_t     exe_b;
    xlen_t     exe_imm;
    xlen_t     exe_pc4;
    reg_addr_t exe_rd_in;
    alu_op_e   exe_alu_op;
    logic      exe_alu_imm;
    logic      exe_wreg_in;
    logic      exe_wmem;
    logic      exe_link;

    // results fed back for forwarding and writeback
    xlen_t     exe_result;
    xlen_t     mem_result;
    reg_addr_t exe_rd;
    reg_addr_t mem_rd;
    reg_addr_t wb_rd;
    logic      exe_wreg;
    logic      mem_wreg;
    logic      wb_we;
    xlen_t     wb_data;

    fetch_stage u_fetch_stage (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_hold          (hold),
        .i_flush         (flush),
        .i_pc_sel        (pc_sel),
        .i_branch_target (branch_target),
        .i_jal_target    (jal_target),
        .i_instr         (i_instr_rdata),
        .o_pc            (o_instr_addr),
        .o_id_instr      (id_instr),
        .o_id_pc         (id_pc)
    );

    control_unit u_control_unit (
        .i_instr    (id_instr),
        .i_exe_rd   (exe_rd),
        .i_mem_rd   (mem_rd),
        .i_exe_wreg (exe_wreg),
        .i_mem_wreg (mem_wreg),
        .i_equal    (equal),
        .o_alu_op   (alu_op),
        .o_alu_imm  (alu_imm),
        .o_wreg     (wreg),
        .o_wmem     (wmem),
        .o_link     (link),
        .o_fwd_a    (fwd_a),
        .o_fwd_b    (fwd_b),
        .o_pc_sel   (pc_sel),
        .o_flush    (flush)
    );

    regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_rs1    (id_instr[19:15]),
        .i_rs2    (id_instr[24:20]),
        .i_rd     (wb_rd),
        .i_we     (wb_we),
        .i_wdata  (wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    decode_stage u_decode_stage (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_hold          (hold),
        .i_instr         (id_instr),
        .i_pc            (id_pc),
        .i_rdata1        (rdata1),
        .i_rdata2        (rdata2),
        .i_exe_result    (exe_result),
        .i_mem_result    (mem_result),
        .i_fwd_a         (fwd_a),
        .i_fwd_b         (fwd_b),
        .i_alu_op        (alu_op),
        .i_alu_imm       (alu_imm),
        .i_wreg          (wreg),
        .i_wmem          (wmem),
        .i_link          (link),
        .o_equal         (equal),
        .o_branch_target (branch_target),
        .o_jal_target    (jal_target),
        .o_exe_a         (exe_a),
        .o_exe_b         (exe_b),
        .o_exe_imm       (exe_imm),
        .o_exe_pc4       (exe_pc4),
        .o_exe_rd        (exe_rd_in),
        .o_exe_alu_op    (exe_alu_op),
        .o_exe_alu_imm   (exe_alu_imm),
        .o_exe_wreg      (exe_wreg_in),
        .o_exe_wmem      (exe_wmem),
        .o_exe_link      (exe_link)
    );

    execute_stage u_execute_stage (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_exe_a       (exe_a),
        .i_exe_b       (exe_b),
        .i_exe_imm     (exe_imm),
        .i_exe_pc4     (exe_pc4),
        .i_exe_rd      (exe_rd_in),
        .i_exe_alu_op  (exe_alu_op),
        .i_exe_alu_imm (exe_alu_imm),
        .i_exe_wreg    (exe_wreg_in),
        .i_exe_wmem    (exe_wmem),
        .i_exe_link    (exe_link),
        .i_data_gnt    (i_data_gnt),
        .o_exe_result  (exe_result),
        .o_mem_result  (mem_result),
        .o_exe_rd      (exe_rd),
        .o_mem_rd      (mem_rd),
        .o_wb_rd       (wb_rd),
        .o_exe_wreg    (exe_wreg),
        .o_mem_wreg    (mem_wreg),
        .o_wb_we       (wb_we),
        .o_wb_data     (wb_data),
        .o_data_req    (o_data_req),
        .o_data_addr   (o_data_addr),
        .o_data_wdata  (o_data_wdata),
        .o_hold        (hold)
    );

endmodule

// File: verification/tb_core.sv
// core_top testbench that runs the trace program and checks each store on the store port
module tb_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 100;
    localparam int          TRACE_WORDS  = 128;
    // word index of the store count that precedes the address/data pairs
    localparam int          STORE_BASE   = 'h40;
    // addi x0 x0 0 returned past the end of the program
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;
    // quiet cycles after the last store to catch extra requests
    localparam int          DRAIN_CYCLES = 10;

    logic        i_clk;
    logic        i_rst_n;
    logic [31:0] o_instr_addr;
    logic [31:0] i_instr_rdata;
    logic        o_data_req;
    logic [31:0] o_data_addr;
    logic [31:0] o_data_wdata;
    logic        i_data_gnt;

    logic [31:0] trace [0:TRACE_WORDS-1];
    int          prog_len;
    int          n_stores;
    int          store_idx;
    int          wait_left;
    bit          pending;
    bit          trace_loaded;
    logic [31:0] held_addr;
    logic [31:0] held_data;
    integer      seed;

    core_top u_core_top (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .o_instr_addr  (o_instr_addr),
        .i_instr_rdata (i_instr_rdata),
        .o_data_req    (o_data_req),
        .o_data_addr   (o_data_addr),
        .o_data_wdata  (o_data_wdata),
        .i_data_gnt    (i_data_gnt)
    );

    // instruction memory answers in the same cycle at word index addr/4
    assign i_instr_rdata = (o_instr_addr[31:2] < prog_len) ? trace[o_instr_addr[31:2]] : NOP_WORD;

    task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    task automatic load_trace();
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace[i] = '0;
        end
        $readmemh("verification/core_trace.txt", trace);
        // a zero word is no legal instruction and ends the program
        prog_len = 0;
        while (prog_len < STORE_BASE && trace[prog_len] != '0) begin
            prog_len++;
        end
        n_stores = trace[STORE_BASE];
    endtask

    // compares a granted store with the next expected pair
    task automatic check_store();
        if (store_idx >= n_stores) begin
            abort_run("a store request appeared after all expected stores had completed");
        end else begin
            expect_equal(o_data_addr, trace[STORE_BASE + 1 + 2 * store_idx],
                         $sformatf("store %0d address", store_idx));
            expect_equal(o_data_wdata, trace[STORE_BASE + 2 + 2 * store_idx],
                         $sformatf("store %0d data", store_idx));
            store_idx++;
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    initial begin
        i_rst_n    = 1'b0;
        i_data_gnt = 1'b0;
        seed       = 32'h6542;
        store_idx  = 0;
        wait_left  = 0;
        pending    = 1'b0;
        load_trace();
        if (prog_len == 0 || n_stores == 0) begin
            abort_run("the trace file is missing or holds no program or no stores");
        end
        trace_loaded = 1'b1;
        // reset held for two cycles and released on a falling edge
        repeat (2) @(negedge i_clk);
        expect_equal(o_instr_addr, 32'h0, "fetch address after reset");
        expect_equal({31'b0, o_data_req}, 32'h0, "store request after reset");
        i_rst_n = 1'b1;
        wait (store_idx == n_stores);
        repeat (DRAIN_CYCLES) @(negedge i_clk);
        $display("NO ERRORS");
        $finish;
    end

    // grant model
    // requests are seen on the falling edge and the grant is driven there too
    always @(negedge i_clk) begin
        if (o_data_req) begin
            if (pending) begin
                expect_equal(o_data_addr, held_addr, "store address moved while waiting");
                expect_equal(o_data_wdata, held_data, "store data moved while waiting");
            end else begin
                // new request waits 0 to 3 cycles for its grant
                wait_left = $unsigned($random(seed)) % 4;
                held_addr = o_data_addr;
                held_data = o_data_wdata;
            end
            if (wait_left == 0) begin
                // granted store completes on the next rising edge
                check_store();
                i_data_gnt = 1'b1;
                pending    = 1'b0;
            end else begin
                i_data_gnt = 1'b0;
                pending    = 1'b1;
                wait_left--;
            end
        end else begin
            i_data_gnt = 1'b0;
            pending    = 1'b0;
        end
    end

    // watchdog limit scales with program length and store count
    initial begin
        wait (trace_loaded);
        repeat (prog_len + 4 * n_stores + 20) @(posedge i_clk);
        abort_run($sformatf("timeout, the expected stores never arrived (%0d of %0d seen)",
                            store_idx, n_stores));
    end

endmodule

// File: verification/core_trace.txt
// program words from address 0, four per line, the first zero word ends the program
// at @40 the store count, then one store per line as address and data
@0
00500093 FFD00113 002081B3 10302023 // 0x00 addi x1 5, addi x2 -3, add x3, sw x3
40208233 10402223 401152B3 10502423 // 0x10 sub x4, sw x4, sra x5, sw x5
00112333 001133B3 10602623 10702823 // 0x20 slt x6, sltu x7, sw x6, sw x7
12345437 67844413 10802A23 00700013 // 0x30 lui x8, xori x8, sw x8, addi x0 7
10002C23 00108463 10102E23 00109463 // 0x40 sw x0, beq taken, sw skipped, bne not taken
12102023 008004EF 12102223 12902423 // 0x50 sw x1, jal x9, sw skipped, sw x9
01C15513 001565B3 00A17633 12B02623 // 0x60 srli x10, or x11, and x12, sw x11
12C02823 00409693 12D02A23          // 0x70 sw x12, slli x13, sw x13
@40
0000000C
00000100 00000002 // add 5 + -3
00000104 00000008 // sub 5 - -3
00000108 FFFFFFFF // sra -3 by 5
0000010C 00000001 // slt signed
00000110 00000000 // sltu unsigned
00000114 12345678 // lui then xori
00000118 00000000 // x0 stays zero
00000120 00000005 // after not-taken bne
00000128 00000058 // jal link pc+4
0000012C 0000000F // or with forwarded srli
00000130 0000000D // and with x10 from memory stage
00000134 00000050 // slli

// File: verilog.f
design/core_pkg.sv
design/ctrl_pkg.sv
design/fetch_stage.sv
design/control_unit.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/core_top.sv
verification/tb_core.sv
